// ==== include/stepper_consts.svh ====
// bus width, memory map, io register offsets and step timing limits
`ifndef STEPPER_CONSTS_SVH
`define STEPPER_CONSTS_SVH

// bus word width in bits
`define DATA_WIDTH 32

// default data ram depth in words
`define RAM_WORDS 256

// address bit that moves an access into io space
`define IO_SEL_BIT 28

// io register byte offsets
`define REG_LED       4'h0
`define REG_MOTOR_CMD 4'h4
`define REG_STATUS    4'h8
`define REG_POSITION  4'hC

// shortest half period the step generator will run, in clock cycles
`define MIN_HALF_PERIOD 2

`endif

// ==== source/stepper_pkg.sv ====
// motor command struct and the union that reads a command word two ways
`include "stepper_consts.svh"

package stepper_pkg;

  // field view of a motor command word
  // enable sits in the top bit, reserved in the bottom two
  typedef struct packed {
    logic        enable;
    logic        dir;
    logic [11:0] half_period;
    logic [15:0] steps;
    logic [1:0]  reserved;
  } motor_cmd_t;

  // raw is the word as the bus wrote it, cmd is what the step generator decodes
  typedef union packed {
    logic [`DATA_WIDTH-1:0] raw;
    motor_cmd_t             cmd;
  } motor_cmd_u;

endpackage

// ==== source/data_ram.sv ====
// word ram with byte strobe writes and a registered one-cycle response
`include "stepper_consts.svh"

module data_ram #(
  parameter int DEPTH = `RAM_WORDS
) (
  input  logic                    clk_in,
  input  logic                    rst_n,
  input  logic                    sel,
  input  logic [31:0]             addr,
  input  logic [`DATA_WIDTH-1:0]  wdata,
  input  logic [3:0]              wstrb,
  output logic [`DATA_WIDTH-1:0]  rdata,
  output logic                    ready
);

  localparam int ADDR_BITS = $clog2(DEPTH);

  logic [`DATA_WIDTH-1:0] mem [DEPTH];
  logic [ADDR_BITS-1:0]   word_idx;
  logic                   access;

  // drop the byte offset, upper bits wrap at depth
  assign word_idx = addr[ADDR_BITS+1:2];
  // serve once per request, the cycle the ready flop is still low
  assign access = sel && !ready;

  // response handshake
  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      ready <= 1'b0;
    end else begin
      ready <= access;
    end
  end

  // storage and read data
  always_ff @(posedge clk_in) begin
    if (access) begin
      rdata <= mem[word_idx];
      // only strobed bytes change
      for (int b = 0; b < 4; b++) begin
        if (wstrb[b]) begin
          mem[word_idx][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

  // the response never outlives its request
  assert property (@(posedge clk_in) disable iff (!rst_n) ready |-> sel);

endmodule

// ==== source/bus_fabric.sv ====
// address decode, held target select, read data mux and unmapped responder
`include "stepper_consts.svh"

module bus_fabric (
  input  logic                   clk_in,
  input  logic                   rst_n,
  input  logic                   mem_valid,
  input  logic [31:0]            mem_addr,
  input  logic [`DATA_WIDTH-1:0] ram_rdata,
  input  logic                   ram_ready,
  input  logic [`DATA_WIDTH-1:0] io_rdata,
  input  logic                   io_ready,
  output logic                   ram_sel,
  output logic                   io_sel,
  output logic [`DATA_WIDTH-1:0] mem_rdata,
  output logic                   mem_ready
);

  logic hit_ram;
  logic hit_io;
  logic unmap_sel;
  logic unmap_ready;
  logic req_active;

  // ram below the io bit, io only in its first sixteen bytes
  assign hit_ram = (mem_addr[31:`IO_SEL_BIT] == '0);
  assign hit_io  = (mem_addr[31:`IO_SEL_BIT+1] == '0) && mem_addr[`IO_SEL_BIT]
                   && (mem_addr[`IO_SEL_BIT-1:4] == '0);

  assign req_active = ram_sel | io_sel | unmap_sel;

  // target register, one select per request until its ready returns
  always_ff @(posedge clk_in) begin
    if (!rst_n || mem_ready) begin
      ram_sel   <= 1'b0;
      io_sel    <= 1'b0;
      unmap_sel <= 1'b0;
    end else if (mem_valid && !req_active) begin
      ram_sel   <= hit_ram;
      io_sel    <= hit_io;
      unmap_sel <= !hit_ram && !hit_io;
    end
  end

  // unmapped space answers itself one cycle after select
  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      unmap_ready <= 1'b0;
    end else begin
      unmap_ready <= unmap_sel && !unmap_ready;
    end
  end

  // return path from the served target
  // unmapped reads fall through to zero
  assign mem_rdata = ram_sel ? ram_rdata :
                     io_sel  ? io_rdata  : '0;
  assign mem_ready = (ram_sel && ram_ready) || (io_sel && io_ready) || unmap_ready;

  assert property (@(posedge clk_in) disable iff (!rst_n)
    $onehot0({ram_sel, io_sel, unmap_sel}));
  assert property (@(posedge clk_in) disable iff (!rst_n) mem_ready |-> mem_valid);

endmodule

// ==== source/io_register.sv ====
// led, motor command, status and position registers on the memory bus
`include "stepper_consts.svh"

module io_register (
  input  logic                    clk_in,
  input  logic                    rst_n,
  input  logic                    sel,
  input  logic [3:0]              addr,
  input  logic [`DATA_WIDTH-1:0]  wdata,
  input  logic [3:0]              wstrb,
  input  logic                    busy,
  input  logic [`DATA_WIDTH-1:0]  position,
  output logic [`DATA_WIDTH-1:0]  rdata,
  output logic                    ready,
  output logic [7:0]              leds,
  output logic                    start,
  output stepper_pkg::motor_cmd_u cmd
);

  logic [3:0] reg_off;
  logic       access;
  logic       write;
  logic       cmd_write;
  logic       rejected;

  // word offset, byte lanes ignored
  assign reg_off   = {addr[3:2], 2'b00};
  assign access    = sel && !ready;
  assign write     = access && (wstrb != 4'b0000);
  assign cmd_write = write && (reg_off == `REG_MOTOR_CMD);

  // bus handshake, one cycle after select
  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      ready <= 1'b0;
    end else begin
      ready <= access;
    end
  end

  // leds, start pulse and sticky reject flag
  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      leds     <= 8'h00;
      start    <= 1'b0;
      rejected <= 1'b0;
    end else begin
      start <= 1'b0;
      if (write && reg_off == `REG_LED && wstrb[0]) begin
        leds <= wdata[7:0];
      end
      // a move in progress drops the new command
      if (cmd_write) begin
        if (busy) begin
          rejected <= 1'b1;
        end else begin
          start <= 1'b1;
        end
      end
      // status read clears the reject flag
      if (access && !write && reg_off == `REG_STATUS) begin
        rejected <= 1'b0;
      end
    end
  end

  // command word, strobed bytes only, kept for read back
  always_ff @(posedge clk_in) begin
    if (cmd_write && !busy) begin
      for (int b = 0; b < 4; b++) begin
        if (wstrb[b]) begin
          cmd.raw[8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

  // read data captured with the ready edge
  always_ff @(posedge clk_in) begin
    if (access) begin
      case (reg_off)
        `REG_LED:       rdata <= {{(`DATA_WIDTH-8){1'b0}}, leds};
        `REG_MOTOR_CMD: rdata <= cmd.raw;
        `REG_STATUS:    rdata <= {{(`DATA_WIDTH-2){1'b0}}, rejected, busy};
        default:        rdata <= position;
      endcase
    end
  end

  // the step generator must be idle whenever a move is launched
  assert property (@(posedge clk_in) disable iff (!rst_n) start |-> !busy);

endmodule

// ==== source/step_generator.sv ====
// step pulse sequencer with phase timer, step counter and signed position
`include "stepper_consts.svh"

module step_generator (
  input  logic                    clk_in,
  input  logic                    rst_n,
  input  logic                    start,
  input  stepper_pkg::motor_cmd_u cmd,
  output logic                    step,
  output logic                    dir,
  output logic                    drv_en,
  output logic                    busy,
  output logic [`DATA_WIDTH-1:0]  position
);

  import stepper_pkg::*;

  motor_cmd_t             new_cmd;
  logic [11:0]            half_req;
  logic [11:0]            half_q;
  logic [11:0]            timer;
  logic [15:0]            remaining;
  logic [`DATA_WIDTH-1:0] pos_up;
  logic [`DATA_WIDTH-1:0] pos_dn;
  logic                   launch;

  assign new_cmd = cmd.cmd;
  assign launch  = start && !busy;

  // clamp short half periods up to the minimum
  assign half_req = (new_cmd.half_period < 12'(`MIN_HALF_PERIOD)) ?
                    12'(`MIN_HALF_PERIOD) : new_cmd.half_period;

  // two's complement position, wraps like the bus word
  assign pos_up = position + 1'b1;
  assign pos_dn = position - 1'b1;

  // half period of the running move
  always_ff @(posedge clk_in) begin
    if (launch) begin
      half_q <= half_req;
    end
  end

  // pulse sequencer
  // first high phase starts on the launch edge
  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      step      <= 1'b0;
      dir       <= 1'b0;
      drv_en    <= 1'b0;
      busy      <= 1'b0;
      position  <= '0;
      timer     <= '0;
      remaining <= '0;
    end else if (launch) begin
      dir       <= new_cmd.dir;
      drv_en    <= new_cmd.enable;
      remaining <= new_cmd.steps;
      timer     <= half_req - 12'd1;
      // zero steps only updates dir and enable
      if (new_cmd.steps != 16'd0) begin
        busy     <= 1'b1;
        step     <= 1'b1;
        position <= new_cmd.dir ? pos_up : pos_dn;
      end
    end else if (busy) begin
      if (timer != 12'd0) begin
        timer <= timer - 12'd1;
      end else if (step) begin
        // high phase done
        step  <= 1'b0;
        timer <= half_q - 12'd1;
      end else if (remaining == 16'd1) begin
        // last low phase done
        busy      <= 1'b0;
        remaining <= 16'd0;
      end else begin
        step      <= 1'b1;
        timer     <= half_q - 12'd1;
        remaining <= remaining - 16'd1;
        position  <= dir ? pos_up : pos_dn;
      end
    end
  end

  assert property (@(posedge clk_in) disable iff (!rst_n) !busy |-> !step);

endmodule

// ==== source/stepper.sv ====
// top level, bus fabric with data ram, io registers and step generator
`include "stepper_consts.svh"

module stepper (
  input  logic                   clk_in,
  input  logic                   rst_n,
  input  logic                   mem_valid,
  input  logic [31:0]            mem_addr,
  input  logic [`DATA_WIDTH-1:0] mem_wdata,
  input  logic [3:0]             mem_wstrb,
  output logic [`DATA_WIDTH-1:0] mem_rdata,
  output logic                   mem_ready,
  output logic [7:0]             leds,
  output logic                   step,
  output logic                   dir,
  output logic                   drv_en
);

  import stepper_pkg::*;

  // fabric to targets
  logic                   ram_sel;
  logic                   io_sel;
  logic [`DATA_WIDTH-1:0] ram_rdata;
  logic                   ram_ready;
  logic [`DATA_WIDTH-1:0] io_rdata;
  logic                   io_ready;

  // io block to step generator
  logic                   motor_start;
  motor_cmd_u             motor_cmd;
  logic                   motor_busy;
  logic [`DATA_WIDTH-1:0] motor_position;

  bus_fabric fabric (
    .clk_in    (clk_in),
    .rst_n     (rst_n),
    .mem_valid (mem_valid),
    .mem_addr  (mem_addr),
    .ram_rdata (ram_rdata),
    .ram_ready (ram_ready),
    .io_rdata  (io_rdata),
    .io_ready  (io_ready),
    .ram_sel   (ram_sel),
    .io_sel    (io_sel),
    .mem_rdata (mem_rdata),
    .mem_ready (mem_ready)
  );

  data_ram #(
    .DEPTH(`RAM_WORDS)
  ) ram (
    .clk_in (clk_in),
    .rst_n  (rst_n),
    .sel    (ram_sel),
    .addr   (mem_addr),
    .wdata  (mem_wdata),
    .wstrb  (mem_wstrb),
    .rdata  (ram_rdata),
    .ready  (ram_ready)
  );

  // io space offset is the low nibble
  io_register io (
    .clk_in   (clk_in),
    .rst_n    (rst_n),
    .sel      (io_sel),
    .addr     (mem_addr[3:0]),
    .wdata    (mem_wdata),
    .wstrb    (mem_wstrb),
    .busy     (motor_busy),
    .position (motor_position),
    .rdata    (io_rdata),
    .ready    (io_ready),
    .leds     (leds),
    .start    (motor_start),
    .cmd      (motor_cmd)
  );

  step_generator stepgen (
    .clk_in   (clk_in),
    .rst_n    (rst_n),
    .start    (motor_start),
    .cmd      (motor_cmd),
    .step     (step),
    .dir      (dir),
    .drv_en   (drv_en),
    .busy     (motor_busy),
    .position (motor_position)
  );

endmodule

// ==== tb/stepper_tb.sv ====
// bus master stimulus, reference model, step monitor, watchdog and verdict for the stepper top
`include "stepper_consts.svh"

module stepper_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import stepper_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int BUS_LATENCY = 2;
  localparam int RAM_TEST_WORDS = `RAM_WORDS;
  localparam int N_RAM_OPS = 64;
  localparam int N_MOVES = 8;
  localparam int MAX_STEPS = 6;
  localparam int MAX_HALF = 6;
  // longest move plus launch and idle edges
  localparam int MOVE_CYCLES = 2 * MAX_HALF * MAX_STEPS + 2;
  localparam int N_ACCESS = 2 * RAM_TEST_WORDS + N_RAM_OPS + 16 + 10 * (N_MOVES + 2);
  localparam int LIMIT_CYCLES = 2 * ((N_MOVES + 2) * MOVE_CYCLES + 4 * N_ACCESS + 8);
  localparam logic [31:0] IO_BASE = 32'h1 << `IO_SEL_BIT;

  logic        clk_in;
  logic        rst_n;
  logic        mem_valid;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [3:0]  mem_wstrb;
  logic [31:0] mem_rdata;
  logic        mem_ready;
  logic [7:0]  leds;
  logic        step;
  logic        dir;
  logic        drv_en;

  // reference model state
  integer      seed = 54;
  int          errors = 0;
  int          checks = 0;
  logic [31:0] ram_model [RAM_TEST_WORDS];
  logic [7:0]  led_model;
  logic [31:0] pos_model;
  int          step_edges = 0;
  int          exp_half = 0;
  int          high_len = 0;
  logic        step_prev = 1'b0;

  stepper dut (
    .clk_in    (clk_in),
    .rst_n     (rst_n),
    .mem_valid (mem_valid),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_rdata (mem_rdata),
    .mem_ready (mem_ready),
    .leds      (leds),
    .step      (step),
    .dir       (dir),
    .drv_en    (drv_en)
  );

  initial begin
    clk_in = 1'b0;
    forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
  end

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0d ns: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
    end
  endtask

  // one bus transfer with its latency counted in rising edges after valid goes out
  task automatic access_bus(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output logic [31:0] rdata);
    int   edges;
    logic got_ready;
    edges = 0;
    got_ready = 1'b0;
    @(posedge clk_in);
    mem_valid <= 1'b1;
    mem_addr  <= addr;
    mem_wdata <= data;
    mem_wstrb <= strb;
    while (!got_ready && edges <= 8) begin
      @(negedge clk_in);
      if (mem_ready) begin
        got_ready = 1'b1;
      end else begin
        @(posedge clk_in);
        edges++;
      end
    end
    if (!got_ready) begin
      $display("bus access to 0x%08h never returned ready", addr);
    end
    // read data is valid alongside ready
    rdata = mem_rdata;
    check_value(edges, BUS_LATENCY, "bus latency");
    @(posedge clk_in);
    mem_valid <= 1'b0;
    mem_wstrb <= 4'h0;
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
    logic [31:0] unused;
    access_bus(addr, data, strb, unused);
  endtask

  task automatic read_word(input logic [31:0] addr, output logic [31:0] data);
    access_bus(addr, 32'h0, 4'h0, data);
  endtask

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = data[8*b +: 8];
      end
    end
    return res;
  endfunction

  // initial ram contents that spread over every address bit
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9e37_79b9) ^ {addr[15:0], addr[31:16]};
  endfunction

  // poll status until bit 0 drops
  task automatic wait_idle();
    logic [31:0] status;
    int          polls;
    polls = 0;
    do begin
      read_word(IO_BASE + `REG_STATUS, status);
      polls++;
    end while (status[0] && polls < 4 * MOVE_CYCLES);
    if (status[0]) begin
      errors++;
      $display("motor still busy after %0d status polls", polls);
    end
  endtask

  task automatic random_cmd(output motor_cmd_t c);
    logic [31:0] r;
    r = $random(seed);
    c.enable      = r[0];
    c.dir         = r[1];
    c.half_period = 12'(r[4:2] % (MAX_HALF + 1));
    c.steps       = 16'(1 + (r[10:8] % MAX_STEPS));
    c.reserved    = r[13:12];
  endtask

  // one full move checked against pins and registers
  task automatic run_move(input motor_cmd_t c);
    motor_cmd_u  u;
    int          edges_before;
    logic [31:0] got;
    u.cmd = c;
    exp_half = (c.half_period < `MIN_HALF_PERIOD) ? `MIN_HALF_PERIOD : int'(c.half_period);
    edges_before = step_edges;
    write_word(IO_BASE + `REG_MOTOR_CMD, u.raw, 4'hF);
    wait_idle();
    check_value(step_edges - edges_before, c.steps, "step pulse count");
    check_value(dir, c.dir, "dir pin");
    check_value(drv_en, c.enable, "drv_en pin");
    pos_model = c.dir ? pos_model + c.steps : pos_model - c.steps;
    read_word(IO_BASE + `REG_POSITION, got);
    check_value(got, pos_model, "position register");
    read_word(IO_BASE + `REG_MOTOR_CMD, got);
    check_value(got, u.raw, "command read back");
  endtask

  // step edge counter and high phase length sampled away from the rising edge
  always @(negedge clk_in) begin
    if (step && !step_prev) begin
      step_edges++;
      high_len = 1;
    end else if (step) begin
      high_len++;
    end else if (step_prev) begin
      check_value(high_len, exp_half, "step high phase length");
    end
    step_prev = step;
  end

  initial begin
    logic [31:0] rd;
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] d;
    logic [3:0]  s;
    motor_cmd_t  c;
    motor_cmd_u  u;
    int          edges_before;
    rst_n     = 1'b0;
    mem_valid = 1'b0;
    mem_addr  = 32'h0;
    mem_wdata = 32'h0;
    mem_wstrb = 4'h0;
    pos_model = 32'h0;
    repeat (3) @(posedge clk_in);
    rst_n <= 1'b1;
    @(negedge clk_in);
    check_value(mem_ready, 0, "mem_ready after reset");
    check_value(step, 0, "step after reset");
    check_value(drv_en, 0, "drv_en after reset");
    check_value(leds, 0, "leds after reset");
    read_word(IO_BASE + `REG_POSITION, rd);
    check_value(rd, 0, "position after reset");
    read_word(IO_BASE + `REG_STATUS, rd);
    check_value(rd, 0, "status after reset");

    // ram fill then random strobed traffic with aliased upper bits
    for (int i = 0; i < RAM_TEST_WORDS; i++) begin
      a = 32'(i * 4);
      ram_model[i] = fill_word(a);
      write_word(a, ram_model[i], 4'hF);
    end
    for (int n = 0; n < N_RAM_OPS; n++) begin
      r = $random(seed);
      a = {4'h0, r[31:14], r[7:0], 2'b00};
      s = r[11:8];
      if (r[12] && s != 4'h0) begin
        d = $random(seed);
        write_word(a, d, s);
        ram_model[r[7:0]] = merge_bytes(ram_model[r[7:0]], d, s);
      end else begin
        read_word(a, rd);
        check_value(rd, ram_model[r[7:0]], "ram read");
      end
    end

    // unmapped io offset, io page above, upper address bits
    read_word(IO_BASE + 32'h10, rd);
    check_value(rd, 0, "unmapped io offset read");
    read_word(IO_BASE + 32'h0ff0_0000, rd);
    check_value(rd, 0, "unmapped io page read");
    read_word(32'h2000_0000, rd);
    check_value(rd, 0, "unmapped upper read");
    read_word(32'hf000_0004, rd);
    check_value(rd, 0, "unmapped top read");
    write_word(32'h2000_0000, 32'hdead_beef, 4'hF);
    read_word(32'h0, rd);
    check_value(rd, ram_model[0], "ram word 0 after unmapped write");

    // leds
    repeat (4) begin
      d = $random(seed);
      write_word(IO_BASE + `REG_LED, d, 4'hF);
      led_model = d[7:0];
      check_value(leds, led_model, "leds pins");
      read_word(IO_BASE + `REG_LED, rd);
      check_value(rd, {24'h0, led_model}, "led read back");
    end

    // random moves with the first two below the minimum half period
    for (int i = 0; i < N_MOVES; i++) begin
      random_cmd(c);
      if (i < 2) begin
        c.half_period = 12'(i);
      end
      run_move(c);
    end

    // second command while busy is dropped and flagged once
    c = '{enable: 1'b1, dir: 1'b0, half_period: 12'd3, steps: 16'd4, reserved: 2'b00};
    u.cmd = c;
    exp_half = 3;
    edges_before = step_edges;
    write_word(IO_BASE + `REG_MOTOR_CMD, u.raw, 4'hF);
    write_word(IO_BASE + `REG_MOTOR_CMD, 32'h4802_0024, 4'hF);
    read_word(IO_BASE + `REG_STATUS, rd);
    check_value(rd[1], 1, "rejected flag set");
    read_word(IO_BASE + `REG_STATUS, rd);
    check_value(rd[1], 0, "rejected flag cleared");
    wait_idle();
    check_value(step_edges - edges_before, 4, "steps with dropped command");
    pos_model = pos_model - 32'd4;
    read_word(IO_BASE + `REG_POSITION, rd);
    check_value(rd, pos_model, "position with dropped command");
    read_word(IO_BASE + `REG_MOTOR_CMD, rd);
    check_value(rd, u.raw, "command kept over dropped one");

    // zero steps leave pulses and busy off
    c = '{enable: 1'b1, dir: 1'b1, half_period: 12'd5, steps: 16'd0, reserved: 2'b00};
    u.cmd = c;
    edges_before = step_edges;
    write_word(IO_BASE + `REG_MOTOR_CMD, u.raw, 4'hF);
    read_word(IO_BASE + `REG_STATUS, rd);
    check_value(rd[0], 0, "busy on zero step command");
    read_word(IO_BASE + `REG_POSITION, rd);
    check_value(rd, pos_model, "position on zero step command");
    check_value(step_edges - edges_before, 0, "pulses on zero step command");

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // bound on the whole run at twice the worst case of all traffic and moves
  initial begin
    #(LIMIT_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the run timed out", LIMIT_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+include
source/stepper_pkg.sv
source/data_ram.sv
source/bus_fabric.sv
source/io_register.sv
source/step_generator.sv
source/stepper.sv
tb/stepper_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = stepper_tb
FILELIST  = project.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = *** TEST FAILED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if grep -qF '$(FAIL_MSG)' $(LOG) || [ $$rc -ne 0 ]; then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
